/* test/dma_golden.txt */
# B id addr len, then len+1 lines of D data strb (strobe active low)
# X dst_addr data is one expected destination write, R id one expected B response
B 1 30001000 7
D a0000000 0
D a0000001 0
D a0000002 0
D a0000003 0
D a0000004 0
D a0000005 0
D a0000006 0
D a0000007 0
R 1
B 2 30000100 0
D 30001000 0
R 2
B 3 30000200 0
D 40000000 0
R 3
B 4 30000300 0
D 00000008 0
R 4
B 5 30000400 0
D 00000001 0
R 5
X 40000000 a0000000
X 40000004 a0000001
X 40000008 a0000002
X 4000000c a0000003
X 40000010 a0000004
X 40000014 a0000005
X 40000018 a0000006
X 4000001c a0000007
B 6 30000100 2
D 30001000 0
D 50000000 0
D 00000003 0
R 6
B 7 30000400 0
D 00000001 0
R 7
X 40000000 a0000000
X 40000004 a0000001
X 40000008 a0000002
X 4000000c a0000003
X 40000010 a0000004
X 40000014 a0000005
X 40000018 a0000006
X 4000001c a0000007
B 8 30000100 0
D 30001010 0
R 8
B 9 30000200 0
D 50000000 0
R 9
B a 30000300 0
D 00000003 0
R a
B b 30000400 0
D 00000001 0
R b
X 50000000 a0000004
X 50000004 a0000005
X 50000008 a0000006
B c 20000000 1
D 11111111 0
D 22222222 0
R c
B d 30000300 0
D 00000000 0
R d
B e 30000400 0
D 00000001 0
R e
B f 30000300 0
D 00000005 1
R f
B 0 30000400 0
D 00000001 0
R 0
B 1 30001008 0
D 12345678 3
R 1
B 2 30000100 0
D 30001008 0
R 2
B 3 30000200 0
D 60000000 0
R 3
B 4 30000300 0
D 00000001 0
R 4
B 5 30000400 0
D 00000001 0
R 5
X 60000000 12340002

/* compile.f */
logic/dma_pkg.sv
logic/dma_cfg_slave.sv
logic/dma_buffer.sv
logic/dma_engine.sv
logic/dma_top.sv
test/dma_checker.sv
test/dma_tb.sv

/* Bender.yml */
package:
  name: dma

sources:
  - logic/dma_pkg.sv
  - logic/dma_cfg_slave.sv
  - logic/dma_buffer.sv
  - logic/dma_engine.sv
  - logic/dma_top.sv
  - target: test
    files:
      - test/dma_checker.sv
      - test/dma_tb.sv

/* test/dma_tb.sv */
`timescale 1ns/1ps

module dma_tb;

	logic              ACLK;
	logic              ARESETn;
	dma_pkg::axi_aw_t  aw;
	logic              awvalid;
	logic              awready;
	dma_pkg::axi_w_t   w;
	logic              wvalid;
	logic              wready;
	dma_pkg::axi_b_t   b;
	logic              bvalid;
	logic              bready;
	dma_pkg::dst_wr_t  dst_wr;
	logic              dma_irq;

	dma_pkg::axi_aw_t aw_q [$];
	dma_pkg::axi_w_t  w_q [$];
	int               irq_seen;
	int               enable_writes;
	int               total_beats;
	int               total_words;
	logic [31:0]      gap_state;
	logic [31:0]      stall_state;

	dma_top u_dma_top (.*);

	dma_checker u_checker (.ACLK(ACLK), .ARESETn(ARESETn), .b(b), .bvalid(bvalid),
		.bready(bready), .dst_wr(dst_wr), .dma_irq(dma_irq));

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		ACLK = 1'b0;
		forever #10 ACLK = ~ACLK;
	end

	always @(posedge ACLK) begin
		if (dma_irq) irq_seen++;
	end

	// Bready stalls about one cycle in four
	initial begin
		stall_state = lcg_next(32'hf3d8_6c36 ^ 32'h5a5a_a5a5);
		forever begin
			@(posedge ACLK);
			#1;
			stall_state = lcg_next(stall_state);
			bready = ARESETn && (stall_state[19:18] != 2'd0);
		end
	end

	task automatic load_golden();
		int fd;
		int r;
		int left;
		string tok;
		string line;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] n;
		dma_pkg::axi_aw_t aw_rec;
		dma_pkg::axi_w_t  w_rec;
		fd = $fopen("test/dma_golden.txt", "r");
		if (fd == 0) begin
			$display("testbench could not open the golden file");
			return;
		end
		left = 0;
		while (!$feof(fd)) begin
			r = $fscanf(fd, "%s", tok);
			if (r != 1) break;
			if (tok == "B") begin
				r = $fscanf(fd, "%h %h %h", a, d, n);
				aw_rec = '{id: a[3:0], addr: d, len: n[3:0], size: 3'b010, burst: 2'b01};
				aw_q.push_back(aw_rec);
				left = n + 1;
			end else if (tok == "D") begin
				r = $fscanf(fd, "%h %h", d, n);
				left--;
				w_rec = '{data: d, strb: n[3:0], last: (left == 0)};
				w_q.push_back(w_rec);
				total_beats++;
			end else begin
				if (tok == "X") total_words++;
				r = $fgets(line, fd);
			end
		end
		$fclose(fd);
	endtask

	task automatic idle_gap();
		gap_state = lcg_next(gap_state);
		repeat (gap_state[17:16]) begin
			@(posedge ACLK);
			#1;
		end
	endtask

	task automatic send_burst();
		dma_pkg::axi_aw_t cur;
		logic enables;
		int irq_before;
		cur = aw_q.pop_front();
		enables = (cur.addr == dma_pkg::ADDR_DMAEN) && (w_q[0].data != '0) && (w_q[0].strb == '0);
		irq_before = irq_seen;
		aw = cur;
		awvalid = 1'b1;
		do @(negedge ACLK); while (!awready);
		@(posedge ACLK);
		#1;
		awvalid = 1'b0;
		for (int i = 0; i <= cur.len; i++) begin
			idle_gap();
			w = w_q.pop_front();
			wvalid = 1'b1;
			do @(negedge ACLK); while (!wready);
			@(posedge ACLK);
			#1;
			wvalid = 1'b0;
		end
		do @(negedge ACLK); while (!(bvalid && bready));
		@(posedge ACLK);
		#1;
		if (enables) begin
			enable_writes++;
			while (irq_seen == irq_before) begin // Copy done
				@(posedge ACLK);
				#1;
			end
		end
	endtask

	initial begin
		int limit;
		int errs;
		int missing;
		int irq_errs;
		ARESETn = 1'b0;
		aw = '0;
		awvalid = 1'b0;
		w = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		irq_seen = 0;
		enable_writes = 0;
		total_beats = 0;
		total_words = 0;
		gap_state = 32'hf3d8_6c36;
		load_golden();
		limit = (total_beats + total_words) * 8 + 1000;
		fork
			begin
				repeat (limit) @(posedge ACLK);
				$display("timeout: run did not finish within %0d cycles", limit);
				$display("Test failed");
				$finish;
			end
		join_none
		repeat (10) @(posedge ACLK);
		#1;
		ARESETn = 1'b1;
		while (aw_q.size() > 0) send_burst();
		repeat (30) @(posedge ACLK); // Catch stray writes
		missing = u_checker.exp_addr.size() + u_checker.exp_id.size();
		if (missing != 0) $display("%0d expected events never happened", missing);
		irq_errs = 0;
		if (irq_seen != enable_writes) begin
			$display("saw %0d interrupts for %0d enable writes", irq_seen, enable_writes);
			irq_errs = 1;
		end
		errs = u_checker.data_errs + u_checker.resp_errs + u_checker.other_errs + missing
			+ irq_errs;
		$display("errors: data %0d, response %0d, other %0d, missing %0d, interrupt %0d",
			u_checker.data_errs, u_checker.resp_errs, u_checker.other_errs, missing, irq_errs);
		if (errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* test/dma_checker.sv */
`timescale 1ns/1ps

module dma_checker (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  dma_pkg::axi_b_t    b,
	input  logic               bvalid,
	input  logic               bready,
	input  dma_pkg::dst_wr_t   dst_wr,
	input  logic               dma_irq
);

	logic [dma_pkg::ADDR_BITS-1:0] exp_addr [$];
	logic [dma_pkg::DATA_BITS-1:0] exp_data [$];
	logic [dma_pkg::ID_BITS-1:0]   exp_id [$];
	int data_errs;
	int resp_errs;
	int other_errs;
	logic irq_q;

	// Only X and R records matter here
	initial begin
		int fd;
		int r;
		string tok;
		string line;
		logic [31:0] a;
		logic [31:0] d;
		data_errs  = 0;
		resp_errs  = 0;
		other_errs = 0;
		fd = $fopen("test/dma_golden.txt", "r");
		if (fd == 0) begin
			$display("checker could not open the golden file");
			other_errs++;
		end else begin
			while (!$feof(fd)) begin
				r = $fscanf(fd, "%s", tok);
				if (r != 1) break;
				if (tok == "X") begin
					r = $fscanf(fd, "%h %h", a, d);
					exp_addr.push_back(a);
					exp_data.push_back(d);
				end else if (tok == "R") begin
					r = $fscanf(fd, "%h", a);
					exp_id.push_back(a[dma_pkg::ID_BITS-1:0]);
				end else begin
					r = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end
	end

	always @(posedge ACLK) begin
		if (!ARESETn) begin
			irq_q <= 1'b0;
		end else begin
			irq_q <= dma_irq;
			if (irq_q && dma_irq) begin
				$display("interrupt stayed high for more than one cycle at %0t", $time);
				other_errs++;
			end
			if (dst_wr.valid) begin
				if (exp_addr.size() == 0) begin
					$display("unexpected destination write to %h at %0t", dst_wr.addr, $time);
					other_errs++;
				end else begin
					if (dst_wr.addr !== exp_addr[0] || dst_wr.data !== exp_data[0]) begin
						$display("error at %0t: dst write %h <- %h, expected %h <- %h", $time,
							dst_wr.addr, dst_wr.data, exp_addr[0], exp_data[0]);
						data_errs++;
					end
					void'(exp_addr.pop_front());
					void'(exp_data.pop_front());
				end
			end
			if (bvalid && bready) begin
				if (exp_id.size() == 0) begin
					$display("unexpected write response with id %h at %0t", b.id, $time);
					other_errs++;
				end else begin
					if (b.id !== exp_id[0] || b.resp !== dma_pkg::RESP_OKAY) begin
						$display("error at %0t: B id %h resp %b, expected id %h resp %b", $time,
							b.id, b.resp, exp_id[0], dma_pkg::RESP_OKAY);
						resp_errs++;
					end
					void'(exp_id.pop_front());
				end
			end
		end
	end

endmodule

/* logic/dma_top.sv */
`timescale 1ns/1ps

module dma_top (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  dma_pkg::axi_aw_t   aw,
	input  logic               awvalid,
	output logic               awready,
	input  dma_pkg::axi_w_t    w,
	input  logic               wvalid,
	output logic               wready,
	output dma_pkg::axi_b_t    b,
	output logic               bvalid,
	input  logic               bready,
	output dma_pkg::dst_wr_t   dst_wr,
	output logic               dma_irq
);

	dma_pkg::dma_cfg_t                cfg;
	dma_pkg::buf_wr_t                 buf_wr;
	logic [dma_pkg::BUF_IDX_BITS-1:0] rd_idx;
	logic [dma_pkg::DATA_BITS-1:0]    rd_data;

	dma_cfg_slave u_cfg_slave (
		.ACLK               (ACLK),
		.ARESETn            (ARESETn),
		.aw                 (aw),
		.awvalid            (awvalid),
		.awready            (awready),
		.w                  (w),
		.wvalid             (wvalid),
		.wready             (wready),
		.b                  (b),
		.bvalid             (bvalid),
		.bready             (bready),
		.external_interrupt (dma_irq), // Clears en after each copy
		.cfg                (cfg),
		.buf_wr             (buf_wr)
	);

	dma_buffer u_buffer (
		.ACLK    (ACLK),
		.wr      (buf_wr),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

	dma_engine u_engine (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.cfg     (cfg),
		.rd_data (rd_data),
		.rd_idx  (rd_idx),
		.dst_wr  (dst_wr),
		.irq     (dma_irq)
	);

endmodule

/* logic/dma_engine.sv */
`timescale 1ns/1ps

module dma_engine (
	input  logic                               ACLK,
	input  logic                               ARESETn,
	input  dma_pkg::dma_cfg_t                  cfg,
	input  logic [dma_pkg::DATA_BITS-1:0]      rd_data,
	output logic [dma_pkg::BUF_IDX_BITS-1:0]   rd_idx,
	output dma_pkg::dst_wr_t                   dst_wr,
	output logic                               irq
);

	dma_pkg::engine_state_e state, state_nx;

	logic [dma_pkg::BUF_IDX_BITS-1:0] idx_q;
	logic [dma_pkg::ADDR_BITS-1:0]    addr_q;
	logic [31:0]                      len_q;
	logic [31:0]                      cnt_q;
	logic                             start;
	logic                             last_word;

	assign start     = (state == dma_pkg::E_IDLE) && cfg.en;
	assign last_word = (cnt_q + 32'd1 == len_q);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= dma_pkg::E_IDLE;
		end else begin
			state <= state_nx;
		end
	end

	always_comb begin
		case (state)
			dma_pkg::E_IDLE: begin
				if (!cfg.en) begin
					state_nx = dma_pkg::E_IDLE;
				end else if (cfg.len == '0) begin
					state_nx = dma_pkg::E_DONE; // Nothing to copy
				end else begin
					state_nx = dma_pkg::E_READ;
				end
			end
			dma_pkg::E_READ: begin
				state_nx = dma_pkg::E_WRITE;
			end
			dma_pkg::E_WRITE: begin
				state_nx = last_word ? dma_pkg::E_DONE : dma_pkg::E_READ;
			end
			dma_pkg::E_DONE: begin
				// Slave drops en at the end of this cycle
				state_nx = dma_pkg::E_IDLE;
			end
			default: begin
				state_nx = dma_pkg::E_IDLE;
			end
		endcase
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			len_q <= '0;
			cnt_q <= '0;
		end else if (start) begin
			len_q <= cfg.len;
			cnt_q <= '0;
		end else if (state == dma_pkg::E_WRITE) begin
			cnt_q <= cnt_q + 32'd1;
		end
	end

	// Running buffer index and destination address
	always_ff @(posedge ACLK) begin
		if (start) begin
			idx_q  <= cfg.src[dma_pkg::BUF_IDX_BITS+1:2];
			addr_q <= cfg.dst;
		end else if (state == dma_pkg::E_WRITE) begin
			idx_q  <= idx_q + 1'b1; // Wraps at buffer end
			addr_q <= addr_q + 32'd4;
		end
	end

	assign rd_idx = idx_q;

	always_comb begin
		dst_wr.valid = (state == dma_pkg::E_WRITE);
		dst_wr.addr  = addr_q;
		dst_wr.data  = rd_data;
	end

	assign irq = (state == dma_pkg::E_DONE);

	// Writes only while words remain
	a_dst_in_len: assert property (@(posedge ACLK) disable iff (!ARESETn)
		dst_wr.valid |-> (cnt_q < len_q));

	a_cnt_bound: assert property (@(posedge ACLK) disable iff (!ARESETn)
		cnt_q <= len_q);

endmodule

/* logic/dma_buffer.sv */
`timescale 1ns/1ps

module dma_buffer (
	input  logic                               ACLK,
	input  dma_pkg::buf_wr_t                   wr,
	input  logic [dma_pkg::BUF_IDX_BITS-1:0]   rd_idx,
	output logic [dma_pkg::DATA_BITS-1:0]      rd_data
);

	logic [dma_pkg::DATA_BITS-1:0] mem [dma_pkg::BUF_WORDS];

	// Strobe bit low enables its byte lane
	always_ff @(posedge ACLK) begin
		if (wr.en) begin
			for (int i = 0; i < dma_pkg::STRB_BITS; i++) begin
				if (!wr.strb[i]) begin
					mem[wr.idx][8*i +: 8] <= wr.data[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge ACLK) begin
		rd_data <= mem[rd_idx]; // One cycle read latency
	end

endmodule

/* logic/dma_cfg_slave.sv */
`timescale 1ns/1ps

module dma_cfg_slave (
	input  logic               ACLK,
	input  logic               ARESETn,
	input  dma_pkg::axi_aw_t   aw,
	input  logic               awvalid,
	output logic               awready,
	input  dma_pkg::axi_w_t    w,
	input  logic               wvalid,
	output logic               wready,
	output dma_pkg::axi_b_t    b,
	output logic               bvalid,
	input  logic               bready,
	input  logic               external_interrupt,
	output dma_pkg::dma_cfg_t  cfg,
	output dma_pkg::buf_wr_t   buf_wr
);

	dma_pkg::slave_state_e cs, ns;

	logic [dma_pkg::ID_BITS-1:0]   awid_q;
	logic [dma_pkg::ADDR_BITS-1:0] awaddr_q;
	logic [dma_pkg::LEN_BITS-1:0]  beat_cnt;
	logic [dma_pkg::ADDR_BITS-1:0] beat_off;
	logic [dma_pkg::ADDR_BITS-1:0] beat_addr;
	logic                          beat;
	logic                          full_strb;
	logic                          in_buf;

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			cs <= dma_pkg::IDLE;
		end else begin
			cs <= ns;
		end
	end

	always_comb begin
		case (cs)
			dma_pkg::IDLE: begin
				ns = awvalid ? dma_pkg::WRITE_ADDR : dma_pkg::IDLE;
			end
			dma_pkg::WRITE_ADDR: begin
				ns = (awvalid && awready) ? dma_pkg::WRITE_DATA : dma_pkg::WRITE_ADDR;
			end
			dma_pkg::WRITE_DATA: begin
				ns = (beat && w.last) ? dma_pkg::WRITE_BACK : dma_pkg::WRITE_DATA;
			end
			dma_pkg::WRITE_BACK: begin
				ns = (bvalid && bready) ? dma_pkg::IDLE : dma_pkg::WRITE_BACK;
			end
			default: begin
				ns = dma_pkg::IDLE;
			end
		endcase
	end

	assign awready = (cs == dma_pkg::WRITE_ADDR);
	assign wready  = (cs == dma_pkg::WRITE_DATA);
	assign bvalid  = (cs == dma_pkg::WRITE_BACK);
	assign beat    = wready && wvalid;

	always_ff @(posedge ACLK) begin
		if (awvalid && awready) begin
			awid_q   <= aw.id;
			awaddr_q <= aw.addr;
		end
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			beat_cnt <= '0;
		end else if (cs != dma_pkg::WRITE_DATA) begin
			beat_cnt <= '0;
		end else if (beat) begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// INCR addressing with 4-byte beats
	assign beat_off  = {{(dma_pkg::ADDR_BITS - dma_pkg::LEN_BITS - 2){1'b0}}, beat_cnt, 2'b00};
	assign beat_addr = awaddr_q + beat_off;
	assign full_strb = (w.strb == '0);
	assign in_buf    = (beat_addr >= dma_pkg::BUF_BASE) && (beat_addr < dma_pkg::BUF_END);

	always_comb begin
		b.id   = awid_q;
		b.resp = dma_pkg::RESP_OKAY;
	end

	always_comb begin
		buf_wr.en   = beat && in_buf;
		buf_wr.idx  = beat_addr[dma_pkg::BUF_IDX_BITS+1:2];
		buf_wr.data = w.data;
		buf_wr.strb = w.strb;
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			cfg <= '0;
		end else begin
			if (beat && beat_addr == dma_pkg::ADDR_DMAEN) begin
				cfg.en <= full_strb && (w.data != '0);
			end else if (external_interrupt) begin
				cfg.en <= 1'b0; // Copy finished
			end
			if (beat) begin
				case (beat_addr)
					dma_pkg::ADDR_DMASRC: cfg.src <= full_strb ? w.data : '0;
					dma_pkg::ADDR_DMADST: cfg.dst <= full_strb ? w.data : '0;
					dma_pkg::ADDR_DMALEN: cfg.len <= full_strb ? w.data : '0;
					default: ;
				endcase
			end
		end
	end

	// Every data phase starts from beat zero
	a_beat_restart: assert property (@(posedge ACLK) disable iff (!ARESETn)
		$rose(wready) |-> (beat_cnt == '0));

	a_b_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
		bvalid && !bready |=> bvalid && $stable(b.id));

endmodule

/* logic/dma_pkg.sv */
package dma_pkg;

	// AXI and datapath widths
	localparam int ID_BITS      = 4;
	localparam int ADDR_BITS    = 32;
	localparam int LEN_BITS     = 4;
	localparam int SIZE_BITS    = 3;
	localparam int DATA_BITS    = 32;
	localparam int STRB_BITS    = 4;
	localparam int BUF_WORDS    = 256;
	localparam int BUF_IDX_BITS = 8;

	localparam logic [ADDR_BITS-1:0] ADDR_DMASRC = 32'h3000_0100;
	localparam logic [ADDR_BITS-1:0] ADDR_DMADST = 32'h3000_0200;
	localparam logic [ADDR_BITS-1:0] ADDR_DMALEN = 32'h3000_0300;
	localparam logic [ADDR_BITS-1:0] ADDR_DMAEN  = 32'h3000_0400;
	localparam logic [ADDR_BITS-1:0] BUF_BASE    = 32'h3000_1000;
	localparam logic [ADDR_BITS-1:0] BUF_END     = BUF_BASE + BUF_WORDS * 4; // One past the window

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef struct packed {
		logic [ID_BITS-1:0]   id;
		logic [ADDR_BITS-1:0] addr;
		logic [LEN_BITS-1:0]  len;
		logic [SIZE_BITS-1:0] size;
		logic [1:0]           burst;
	} axi_aw_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic [STRB_BITS-1:0] strb; // Active low
		logic                 last;
	} axi_w_t;

	typedef struct packed {
		logic [ID_BITS-1:0] id;
		logic [1:0]         resp;
	} axi_b_t;

	typedef struct packed {
		logic        en;
		logic [31:0] src;
		logic [31:0] dst;
		logic [31:0] len;
	} dma_cfg_t;

	typedef struct packed {
		logic                    en;
		logic [BUF_IDX_BITS-1:0] idx;
		logic [DATA_BITS-1:0]    data;
		logic [STRB_BITS-1:0]    strb;
	} buf_wr_t;

	typedef struct packed {
		logic                 valid;
		logic [ADDR_BITS-1:0] addr;
		logic [DATA_BITS-1:0] data;
	} dst_wr_t;

	typedef enum logic [1:0] {IDLE, WRITE_ADDR, WRITE_DATA, WRITE_BACK} slave_state_e;

	typedef enum logic [1:0] {E_IDLE, E_READ, E_WRITE, E_DONE} engine_state_e;

endpackage
